/* include/bank_defs.svh */
`ifndef BANK_DEFS_SVH
`define BANK_DEFS_SVH

`default_nettype none

// data word width
`define D_W        32
// word address width of the whole storage, both banks
`define A_W        10
// row width inside one bank
`define ROW_W      (`A_W - 1)
// words per FIFO, split evenly over the two banks
`define F_D        256
`define FIFO_N     3
// returned when no bank delivers a word
`define EMPTY_WORD {`D_W{1'b1}}

`default_nettype wire

`endif

/* hdl/bank_pkg.sv */
`include "bank_defs.svh"
`default_nettype none

package bank_pkg;

    // data word on the bus and in the banks
    typedef logic [`D_W-1:0] word_t;

    // random-access word address, bit 0 picks the bank
    typedef logic [`A_W-1:0] word_addr_t;

    typedef logic [`ROW_W-1:0] bank_row_t;

    // slot in the FIFO window, slot 3 is control
    typedef logic [1:0] fifo_sel_t;

    // occupancy 0 to F_D needs one bit more than the pointers
    typedef logic [$clog2(`F_D):0] fifo_count_t;

    // front-end request sequence
    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_ack
    } wb_state_t;

endpackage

`default_nettype wire

/* hdl/single_port_ram.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module single_port_ram
    import bank_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  ena,
    input  wire logic  wea,
    input  wire logic  flush,
    input  wire word_t din,
    input  wire bank_row_t addr,
    output word_t      dout,
    output logic       read_valid
);

    localparam int DEPTH = 2 ** `ROW_W;

    word_t mem [DEPTH];

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (ena) begin
            if (wea) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

    // high only in the cycle after a read
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            read_valid <= 1'b0;
        end else begin
            read_valid <= ena && !wea;
        end
    end

endmodule

`default_nettype wire

/* hdl/fifo_ctrl.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module fifo_ctrl
    import bank_pkg::*;
#(
    // first row of this FIFO's region in both banks
    parameter bank_row_t FIFO_BASE = '0
)
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push,
    input  wire logic  pop,
    input  wire logic  flush,
    output logic [1:0] bank_en,
    output logic       bank_we,
    output bank_row_t  row,
    output logic       empty,
    output logic       full
);

    localparam int PTR_W = $clog2(`F_D);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] cmd_ptr;
    fifo_count_t      count;
    fifo_count_t      count_nxt;
    logic             do_push;
    logic             do_pop;

    // full drops the push, empty leaves the banks alone
    assign do_push = push && !full;
    assign do_pop  = pop && !push && !empty;

    // entry n lives in bank n%2, row n/2 of the region
    assign cmd_ptr = do_push ? wr_ptr : rd_ptr;

    assign bank_en = !(do_push || do_pop) ? 2'b00 :
                     cmd_ptr[0]           ? 2'b10 :
                                            2'b01;
    assign bank_we = do_push;
    assign row     = FIFO_BASE + bank_row_t'(cmd_ptr[PTR_W-1:1]);

    always_comb begin
        count_nxt = count;
        if (do_push) begin
            count_nxt = count + 1'b1;
        end else if (do_pop) begin
            count_nxt = count - 1'b1;
        end
    end

    // pointers wrap at F_D by their width
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_nxt;
            // flags follow the new count at the same edge
            empty <= (count_nxt == '0);
            full  <= (count_nxt == fifo_count_t'(`F_D));
        end
    end

endmodule

`default_nettype wire

/* hdl/bankgroup.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module bankgroup
    import bank_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       en,
    input  wire logic       pattern,
    input  wire fifo_sel_t  fifo_sel,
    input  wire word_addr_t addr,
    input  wire logic       we,
    input  wire word_t      din,
    input  wire logic       flush,
    output word_t           dout,
    output logic [`FIFO_N-1:0] fifo_empty,
    output logic [`FIFO_N-1:0] fifo_full
);

    localparam int ROWS_PER_FIFO = `F_D / 2;

    logic [`FIFO_N-1:0] push;
    logic [`FIFO_N-1:0] pop;
    logic [1:0]         f_bank_en [`FIFO_N];
    logic               f_bank_we [`FIFO_N];
    bank_row_t          f_row     [`FIFO_N];
    logic               fifo_hit;

    logic [1:0]         ram_en;
    logic               ram_we;
    bank_row_t          ram_row;
    word_t              ram_dout  [2];
    logic [1:0]         ram_valid;

    // one controller per FIFO, each with its own row region
    for (genvar k = 0; k < `FIFO_N; k++) begin : g_fifo
        assign push[k] = en && pattern && we && (fifo_sel == fifo_sel_t'(k));
        assign pop[k]  = en && pattern && !we && (fifo_sel == fifo_sel_t'(k));

        fifo_ctrl #(
            .FIFO_BASE (bank_row_t'(k * ROWS_PER_FIFO))
        ) fifo_i (
            .clk     (clk),
            .rst     (rst),
            .push    (push[k]),
            .pop     (pop[k]),
            .flush   (flush),
            .bank_en (f_bank_en[k]),
            .bank_we (f_bank_we[k]),
            .row     (f_row[k]),
            .empty   (fifo_empty[k]),
            .full    (fifo_full[k])
        );
    end

    // slot 3 is the control slot, no controller behind it
    assign fifo_hit = (fifo_sel < fifo_sel_t'(`FIFO_N));

    // bank command select, FIFO controller or random address
    always_comb begin
        if (pattern) begin
            if (fifo_hit) begin
                ram_en  = f_bank_en[fifo_sel];
                ram_we  = f_bank_we[fifo_sel];
                ram_row = f_row[fifo_sel];
            end else begin
                ram_en  = 2'b00;
                ram_we  = 1'b0;
                ram_row = '0;
            end
        end else begin
            // bit 0 picks the bank, bits 9:1 the row
            ram_en  = !en     ? 2'b00 :
                      addr[0] ? 2'b10 :
                                2'b01;
            ram_we  = we;
            ram_row = addr[`A_W-1:1];
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        single_port_ram ram_i (
            .clk        (clk),
            .rst        (rst),
            .ena        (ram_en[b]),
            .wea        (ram_we),
            .flush      (flush),
            .din        (din),
            .addr       (ram_row),
            .dout       (ram_dout[b]),
            .read_valid (ram_valid[b])
        );
    end

    // nothing read means the empty word
    assign dout = ram_valid[0] ? ram_dout[0] :
                  ram_valid[1] ? ram_dout[1] :
                                 `EMPTY_WORD;

endmodule

`default_nettype wire

/* hdl/wb_bank_port.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module wb_bank_port
    import bank_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [11:0] wb_adr,
    input  wire word_t       wb_dat_w,
    input  wire word_t       dout,
    input  wire logic [`FIFO_N-1:0] fifo_empty,
    input  wire logic [`FIFO_N-1:0] fifo_full,
    output word_t            wb_dat_r,
    output logic             wb_ack,
    output logic             en,
    output logic             pattern,
    output fifo_sel_t        fifo_sel,
    output word_addr_t       addr,
    output logic             we,
    output word_t            din,
    output logic             flush
);

    wb_state_t  state;
    logic       req_fifo;
    logic       req_we;
    word_addr_t req_addr;
    word_t      req_dat;
    logic       ctrl_slot;
    word_t      status;

    // request sequence, idle -> issue -> ack -> idle
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // the ack cycle still shows the old stb
                    if (wb_cyc && wb_stb && !wb_ack) begin
                        state <= st_issue;
                    end
                end
                st_issue: state <= st_ack;
                st_ack:   state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // hold the request for the bank command
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            req_fifo <= wb_adr[11];
            req_we   <= wb_we;
            req_addr <= wb_adr[`A_W-1:0];
            req_dat  <= wb_dat_w;
        end
    end

    assign ctrl_slot = req_fifo && (req_addr[1:0] == 2'd3);

    // one-cycle bank command
    assign en       = (state == st_issue);
    assign pattern  = req_fifo;
    assign fifo_sel = req_addr[1:0];
    assign addr     = req_addr;
    assign we       = req_we;
    assign din      = req_dat;
    assign flush    = en && ctrl_slot && req_we;

    // empty flags in 2:0, full flags in 6:4
    always_comb begin
        status = '0;
        status[`FIFO_N-1:0] = fifo_empty;
        status[4 +: `FIFO_N] = fifo_full;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= (state == st_ack);
        end
    end

    // bank data is valid during st_ack
    always_ff @(posedge clk) begin
        if (state == st_ack) begin
            wb_dat_r <= (ctrl_slot && !req_we) ? status : dout;
        end
    end

endmodule

`default_nettype wire

/* hdl/bank_store_top.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module bank_store_top
    import bank_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        wb_cyc,
    input  wire logic        wb_stb,
    input  wire logic        wb_we,
    input  wire logic [11:0] wb_adr,
    input  wire word_t       wb_dat_w,
    output word_t            wb_dat_r,
    output logic             wb_ack
);

    // bank command from the port
    logic       en;
    logic       pattern;
    fifo_sel_t  fifo_sel;
    word_addr_t addr;
    logic       we;
    word_t      din;
    logic       flush;

    // bank group response
    word_t              dout;
    logic [`FIFO_N-1:0] fifo_empty;
    logic [`FIFO_N-1:0] fifo_full;

    wb_bank_port port_i (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .dout       (dout),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .en         (en),
        .pattern    (pattern),
        .fifo_sel   (fifo_sel),
        .addr       (addr),
        .we         (we),
        .din        (din),
        .flush      (flush)
    );

    bankgroup group_i (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .pattern    (pattern),
        .fifo_sel   (fifo_sel),
        .addr       (addr),
        .we         (we),
        .din        (din),
        .flush      (flush),
        .dout       (dout),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full)
    );

endmodule

`default_nettype wire

/* verification/bank_store_tb.sv */
`timescale 1ns/100ps
`include "bank_defs.svh"
`default_nettype none

module bank_store_tb;

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [11:0]      wb_adr;
    logic [`D_W-1:0]  wb_dat_w;
    logic [`D_W-1:0]  wb_dat_r;
    logic             wb_ack;

    int seed = 32'h3605d86a;
    int errors = 0;
    int checks = 0;

    // reference model, random-access memory and one queue per FIFO
    logic [`D_W-1:0] ref_mem [int];
    logic [`D_W-1:0] q0 [$];
    logic [`D_W-1:0] q1 [$];
    logic [`D_W-1:0] q2 [$];
    int              wr_idx [3];

    bank_store_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #2 clk = ~clk;

    // bus rules
    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $display("ack at %0t while the master had no active strobe", $time);
            errors++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $display("ack at %0t lasted longer than one cycle", $time);
            errors++;
        end

    function automatic logic [11:0] ram_adr(input int a);
        return {2'b00, a[9:0]};
    endfunction

    function automatic logic [11:0] fifo_adr(input int slot);
        return 12'h800 | slot[1:0];
    endfunction

    function automatic int fifo_size(input int k);
        case (k)
            0: return q0.size();
            1: return q1.size();
            default: return q2.size();
        endcase
    endfunction

    // a full FIFO drops the push, the entry also lands in its bank region
    function automatic void model_push(input int k, input logic [`D_W-1:0] d);
        if (fifo_size(k) < `F_D) begin
            case (k)
                0: q0.push_back(d);
                1: q1.push_back(d);
                default: q2.push_back(d);
            endcase
            ref_mem[k * `F_D + wr_idx[k]] = d;
            wr_idx[k] = (wr_idx[k] + 1) % `F_D;
        end
    endfunction

    function automatic logic [`D_W-1:0] model_pop(input int k);
        logic [`D_W-1:0] d;
        d = `EMPTY_WORD;
        if (fifo_size(k) > 0) begin
            case (k)
                0: d = q0.pop_front();
                1: d = q1.pop_front();
                default: d = q2.pop_front();
            endcase
        end
        return d;
    endfunction

    // empty flags in 2:0, full flags in 6:4
    function automatic logic [`D_W-1:0] expected_status();
        logic [`D_W-1:0] s;
        s = '0;
        for (int k = 0; k < 3; k++) begin
            s[k]     = (fifo_size(k) == 0);
            s[4 + k] = (fifo_size(k) == `F_D);
        end
        return s;
    endfunction

    task automatic check_word(input string name, input logic [`D_W-1:0] exp,
                              input logic [`D_W-1:0] got);
        checks++;
        assert (got === exp)
            else begin
                $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
                errors++;
            end
    endtask

    // ack is seen between the rising edges, timeout of 20 cycles
    task automatic wait_ack(output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < 20) begin
            @(negedge clk);
            ok = wb_ack;
            cycles++;
        end
    endtask

    // called and left 0.5 ns after a rising edge
    task automatic wb_write(input logic [11:0] adr, input logic [`D_W-1:0] d);
        logic ok;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = d;
        wait_ack(ok);
        if (!ok) begin
            $display("write to address %h got no ack within 20 cycles", adr);
            errors++;
        end
        @(posedge clk);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [`D_W-1:0] d);
        logic ok;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(ok);
        d = wb_dat_r;
        if (!ok) begin
            $display("read from address %h got no ack within 20 cycles", adr);
            errors++;
        end
        @(posedge clk);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic push_fifo(input int k, input logic [`D_W-1:0] d);
        wb_write(fifo_adr(k), d);
        model_push(k, d);
    endtask

    task automatic pop_fifo(input int k);
        logic [`D_W-1:0] got;
        wb_read(fifo_adr(k), got);
        check_word($sformatf("wb_dat_r (pop fifo %0d)", k), model_pop(k), got);
    endtask

    task automatic check_status();
        logic [`D_W-1:0] got;
        wb_read(fifo_adr(3), got);
        check_word("wb_dat_r (status)", expected_status(), got);
    endtask

    // any write to slot 3 clears all FIFOs
    task automatic flush_fifos();
        wb_write(fifo_adr(3), $random(seed));
        q0.delete();
        q1.delete();
        q2.delete();
        for (int k = 0; k < 3; k++) begin
            wr_idx[k] = 0;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("%s: %s, %0d errors", name, (errors == errs_before) ? "pass" : "fail",
                 errors - errs_before);
    endtask

    initial begin
        int a;
        int k;
        int e0;
        logic [`D_W-1:0] d;
        logic [`D_W-1:0] got;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < 3; i++) begin
            wr_idx[i] = 0;
        end
        repeat (2) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // random access, scattered words and even/odd neighbours
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            a = $random(seed) & 32'h3ff;
            d = $random(seed);
            wb_write(ram_adr(a), d);
            ref_mem[a] = d;
        end
        for (int i = 0; i < 8; i++) begin
            a = $random(seed) & 32'h3fe;
            d = $random(seed);
            wb_write(ram_adr(a), d);
            ref_mem[a] = d;
            wb_write(ram_adr(a + 1), ~d);
            ref_mem[a + 1] = ~d;
        end
        foreach (ref_mem[idx]) begin
            wb_read(ram_adr(idx), got);
            check_word($sformatf("wb_dat_r (word %0d)", idx), ref_mem[idx], got);
        end
        finish_test("random access", e0);

        // interleaved traffic, pushes twice as likely as pops
        e0 = errors;
        check_status();
        for (int i = 0; i < 90; i++) begin
            k = $unsigned($random(seed)) % 3;
            if ($unsigned($random(seed)) % 3 != 0) begin
                push_fifo(k, $random(seed));
            end else begin
                pop_fifo(k);
            end
            check_status();
        end
        finish_test("fifo order", e0);

        e0 = errors;
        for (int j = 0; j < 3; j++) begin
            while (fifo_size(j) > 0) begin
                pop_fifo(j);
            end
            pop_fifo(j);
            pop_fifo(j);
            check_status();
        end
        finish_test("empty fifo", e0);

        // fill fifo 1, one extra push must be dropped
        e0 = errors;
        for (int i = 0; i < `F_D; i++) begin
            push_fifo(1, $random(seed));
        end
        check_status();
        push_fifo(1, $random(seed));
        check_status();
        for (int i = 0; i < `F_D; i++) begin
            pop_fifo(1);
        end
        check_status();
        pop_fifo(1);
        finish_test("full fifo", e0);

        e0 = errors;
        for (int j = 0; j < 3; j++) begin
            for (int i = 0; i < 5; i++) begin
                push_fifo(j, $random(seed));
            end
        end
        flush_fifos();
        check_status();
        for (int j = 0; j < 3; j++) begin
            pop_fifo(j);
            for (int i = 0; i < 4; i++) begin
                push_fifo(j, $random(seed));
            end
            for (int i = 0; i < 4; i++) begin
                pop_fifo(j);
            end
        end
        check_status();
        finish_test("flush", e0);

        // entry n of fifo k sits at word k*F_D + n
        e0 = errors;
        flush_fifos();
        for (int j = 0; j < 3; j++) begin
            for (int n = 0; n < 10; n++) begin
                push_fifo(j, $random(seed));
            end
        end
        flush_fifos();
        for (int j = 0; j < 3; j++) begin
            for (int n = 0; n < 10; n++) begin
                a = j * `F_D + n;
                wb_read(ram_adr(a), got);
                check_word($sformatf("wb_dat_r (alias word %0d)", a), ref_mem[a], got);
            end
        end
        finish_test("aliasing", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
hdl/bank_pkg.sv
hdl/single_port_ram.sv
hdl/fifo_ctrl.sv
hdl/bankgroup.sv
hdl/wb_bank_port.sv
hdl/bank_store_top.sv
verification/bank_store_tb.sv
